// ==== hw/vsldu_cfg_pkg.sv ====
// Geometry is fixed at one register group of 256 bits in 64-bit words; other sizes are not supported
package vsldu_cfg_pkg;

  // Register file geometry
  localparam int unsigned VLEN             = 256;
  localparam int unsigned VRF_WORD_BYTES   = 8;
  localparam int unsigned NR_VREGS         = 32;
  localparam int unsigned NR_WORDS_PER_VEC = 4;
  localparam int unsigned MAXVL_BYTES      = 32;
  localparam int unsigned ELEN             = 32;
  localparam int unsigned BYTE_OFS_W       = 3;
  localparam int unsigned WORD_IDX_W       = 2;

  typedef logic [6:0]  vreg_addr_t;
  typedef logic [63:0] vreg_data_t;
  typedef logic [7:0]  vreg_be_t;
  typedef logic [5:0]  vlen_t;
  typedef logic [4:0]  vreg_idx_t;
  typedef logic [2:0]  op_id_t;

endpackage

// ==== hw/vsldu_isa_pkg.sv ====
// Only slide and scalar-move operations; no masking, LMUL is always one
package vsldu_isa_pkg;

  import vsldu_cfg_pkg::*;

  // Slide opcodes
  typedef enum logic [2:0] {
    OP_SLIDEUP    = 3'd0,
    OP_SLIDEDOWN  = 3'd1,
    OP_SLIDE1UP   = 3'd2,
    OP_SLIDE1DOWN = 3'd3,
    OP_VMVSX      = 3'd4
  } sld_op_e;

  // Element width, also the byte shift for vl and vstart
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vsew_e;

  typedef struct packed {
    sld_op_e          op;
    vsew_e            vsew;
    vlen_t            vl;
    vlen_t            vstart;
    vreg_idx_t        vd;
    vreg_idx_t        vs2;
    logic [ELEN-1:0]  rs1;
    op_id_t           id;
  } sld_req_t;

  typedef struct packed {
    op_id_t id;
  } sld_rsp_t;

  // One byte-enabled register file write
  typedef struct packed {
    vreg_addr_t waddr;
    vreg_data_t wdata;
    vreg_be_t   wbe;
  } vrf_wreq_t;

endpackage

// ==== hw/vrf_port_if.sv ====
// Read data is combinational and valid with re; a write is taken in the cycle wvalid is high
`timescale 1ns/10ps

interface vrf_port_if;

  import vsldu_cfg_pkg::*;
  import vsldu_isa_pkg::*;

  // Read port
  vreg_addr_t raddr;
  logic       re;
  vreg_data_t rdata;
  logic       rvalid;

  // Write port
  vrf_wreq_t  wreq;
  logic       we;
  logic       wvalid;

  modport unit (
    output raddr, re, wreq, we,
    input  rdata, rvalid, wvalid
  );

  modport vrf (
    input  raddr, re, wreq, we,
    output rdata, rvalid, wvalid
  );

endinterface

// ==== hw/spill_register.sv ====
// Two-deep buffer; ready_o depends on own state only and data lags input by one cycle
`timescale 1ns/10ps

module spill_register #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // Stage a takes new data, stage b holds the older item on a stall
  logic a_full_q, b_full_q;
  T     a_data_q, b_data_q;
  logic a_fill, a_drain, b_fill, b_drain;

  assign a_fill  = valid_i & ready_o;
  assign a_drain = a_full_q & ~b_full_q;
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  assign ready_o = ~a_full_q | ~b_full_q;
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

// ==== hw/vsldu.sv ====
// One instruction at a time; vl must not exceed VLMAX and vmv.s.x expects vl of one, vstart zero
`timescale 1ns/10ps

module vsldu (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  vsldu_isa_pkg::sld_req_t req_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  output vsldu_isa_pkg::sld_rsp_t rsp_o,
  output logic                    rsp_valid_o,
  input  logic                    rsp_ready_i,
  vrf_port_if.unit                vrf
);

  import vsldu_cfg_pkg::*;
  import vsldu_isa_pkg::*;

  typedef enum logic {
    ST_RUN,
    ST_WAIT
  } state_e;

  function automatic vreg_data_t rev_bytes(vreg_data_t d);
    vreg_data_t r;
    for (int b = 0; b < VRF_WORD_BYTES; b++) begin
      r[(VRF_WORD_BYTES-1-b)*8 +: 8] = d[b*8 +: 8];
    end
    return r;
  endfunction

  //////////////////////////////////////////////////
  // Request conversion
  //////////////////////////////////////////////////

  logic            accept;
  logic [ELEN+1:0] amt_wide;
  vlen_t           amt_d, vl_d, vstart_d, start_d;
  logic [ELEN-1:0] rs1_d;
  logic            up_d, pf_d, ins_first_d;

  always_comb begin
    vl_d     = req_i.vl << req_i.vsew;
    vstart_d = req_i.vstart << req_i.vsew;

    // Insert ops move by exactly one element
    case (req_i.op)
      OP_SLIDEUP, OP_SLIDEDOWN: amt_wide = {2'b00, req_i.rs1} << req_i.vsew;
      OP_SLIDE1UP, OP_SLIDE1DOWN: amt_wide = (ELEN+2)'(1) << req_i.vsew;
      default: amt_wide = '0;
    endcase
    amt_d = (amt_wide >= MAXVL_BYTES) ? vlen_t'(MAXVL_BYTES) : vlen_t'(amt_wide);

    // Narrow scalars repeated across 32 bits so any aligned element slot sees them
    case (req_i.vsew)
      EW_8:    rs1_d = {4{req_i.rs1[7:0]}};
      EW_16:   rs1_d = {2{req_i.rs1[15:0]}};
      default: rs1_d = req_i.rs1;
    endcase

    up_d        = req_i.op inside {OP_SLIDEUP, OP_SLIDE1UP, OP_VMVSX};
    ins_first_d = (req_i.op == OP_SLIDE1UP && req_i.vstart == '0) || req_i.op == OP_VMVSX;

    // Slide up never writes below the slide amount
    start_d = vstart_d;
    if (up_d && !ins_first_d && vstart_d < amt_d) begin
      start_d = amt_d;
    end
    pf_d = up_d ? (start_d[5:3] > amt_d[5:3]) : 1'b1;
  end

  //////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////

  state_e          state_q;
  logic            busy_q, pf_q;
  vlen_t           cnt_q;
  logic [1:0]      outst_q;

  vsew_e           vsew_q;
  vreg_idx_t       vd_q, vs2_q;
  op_id_t          id_q;
  logic [ELEN-1:0] rs1_q;
  vlen_t           vl_q, amt_q;
  logic            up_q, ins_first_q, ins_last_q;
  vreg_data_t      ovf_q;

  //////////////////////////////////////////////////
  // Word sequencing
  //////////////////////////////////////////////////

  logic [2:0]            cw, aw;
  logic [BYTE_OFS_W-1:0] ofs;
  logic [3:0]            src_word, room, step, end_ofs, es;
  vlen_t                 remaining;
  logic                  last, oob, adv, wpush_valid, wspill_ready, push, pop, done;

  assign cw  = cnt_q[5:3];
  assign aw  = amt_q[5:3];
  assign ofs = amt_q[BYTE_OFS_W-1:0];

  // Slide down reads one word ahead, slide up one word behind during prefetch
  assign src_word = up_q ? ({1'b0, cw} - {1'b0, aw} - {3'b000, pf_q})
                         : ({1'b0, cw} + {1'b0, aw} + {3'b000, ~pf_q});
  assign oob      = ~up_q & (src_word >= NR_WORDS_PER_VEC);

  assign remaining = vl_q - cnt_q;
  assign room      = 4'd8 - {1'b0, cnt_q[BYTE_OFS_W-1:0]};
  assign last      = remaining <= vlen_t'(room);
  assign step      = last ? remaining[3:0] : room;
  assign end_ofs   = {1'b0, cnt_q[BYTE_OFS_W-1:0]} + step;
  assign es        = 4'd1 << vsew_q;

  assign vrf.re    = busy_q;
  assign vrf.raddr = {vs2_q, src_word[WORD_IDX_W-1:0]};

  assign wpush_valid = busy_q & vrf.rvalid & ~pf_q;
  assign adv         = busy_q & vrf.rvalid & (pf_q | wspill_ready);
  assign push        = wpush_valid & wspill_ready;
  assign pop         = vrf.we & vrf.wvalid;

  //////////////////////////////////////////////////
  // Byte shifter
  //////////////////////////////////////////////////

  vreg_data_t din, high, low, merged;
  vrf_wreq_t  wreq_d;

  always_comb begin
    din = up_q ? rev_bytes(vrf.rdata) : vrf.rdata;
    // Past the end of vs2 slide down reads zeros
    if (oob) begin
      din = '0;
    end
    high   = din >> {ofs, 3'b000};
    low    = din << {4'd8 - {1'b0, ofs}, 3'b000};
    merged = up_q ? (high | ovf_q) : (low | ovf_q);

    wreq_d.waddr = {vd_q, cw[WORD_IDX_W-1:0]};
    wreq_d.wdata = up_q ? rev_bytes(merged) : merged;

    for (int i = 0; i < VRF_WORD_BYTES; i++) begin
      wreq_d.wbe[i] = (i >= cnt_q[BYTE_OFS_W-1:0]) && (i < end_ofs);
      // Scalar at element 0
      if (ins_first_q && cnt_q == '0 && i < es) begin
        wreq_d.wdata[i*8 +: 8] = rs1_q[(i%4)*8 +: 8];
      end
      // Scalar at element vl-1
      if (ins_last_q && last && i >= (end_ofs - es)) begin
        wreq_d.wdata[i*8 +: 8] = rs1_q[(i%4)*8 +: 8];
      end
    end
  end

  spill_register #(
    .T(vrf_wreq_t)
  ) i_wreq_spill (
    .clk_i  (clk_i       ),
    .rst_n_i(rst_n_i     ),
    .valid_i(wpush_valid ),
    .ready_o(wspill_ready),
    .data_i (wreq_d      ),
    .valid_o(vrf.we      ),
    .ready_i(vrf.wvalid  ),
    .data_o (vrf.wreq    )
  );

  //////////////////////////////////////////////////
  // Completion
  //////////////////////////////////////////////////

  // Done once the final outstanding write lands in the register file
  assign done        = (outst_q == 2'd0) || (outst_q == 2'd1 && pop);
  assign rsp_valid_o = (state_q == ST_WAIT) & done;
  assign rsp_o       = '{id: id_q};

  assign req_ready_o = (state_q == ST_RUN) & ~busy_q & (outst_q == 2'd0) & rsp_ready_i;
  assign accept      = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_RUN;
      busy_q  <= 1'b0;
      pf_q    <= 1'b0;
      cnt_q   <= '0;
      outst_q <= 2'd0;
    end else begin
      outst_q <= outst_q + {1'b0, push} - {1'b0, pop};
      if (accept) begin
        cnt_q  <= start_d;
        pf_q   <= pf_d;
        busy_q <= start_d < vl_d;
        // Nothing to write, respond straight away
        if (start_d >= vl_d) begin
          state_q <= ST_WAIT;
        end
      end else if (adv) begin
        if (pf_q) begin
          pf_q <= 1'b0;
        end else begin
          cnt_q <= cnt_q + vlen_t'(step);
          if (last) begin
            busy_q  <= 1'b0;
            state_q <= ST_WAIT;
          end
        end
      end
      if (rsp_valid_o && rsp_ready_i) begin
        state_q <= ST_RUN;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      vsew_q      <= req_i.vsew;
      vd_q        <= req_i.vd;
      vs2_q       <= req_i.vs2;
      id_q        <= req_i.id;
      rs1_q       <= rs1_d;
      vl_q        <= vl_d;
      amt_q       <= amt_d;
      up_q        <= up_d;
      ins_first_q <= ins_first_d;
      ins_last_q  <= req_i.op == OP_SLIDE1DOWN;
      ovf_q       <= '0;
    end else if (adv) begin
      ovf_q <= up_q ? low : high;
    end
  end

endmodule

// ==== hw/vrf.sv ====
// Host port is served only when the unit neither reads nor writes; host writes are full words
`timescale 1ns/10ps

module vrf (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  vrf_port_if.vrf                  port,
  input  logic                     host_req_i,
  input  logic                     host_we_i,
  input  vsldu_cfg_pkg::vreg_addr_t host_addr_i,
  input  vsldu_cfg_pkg::vreg_data_t host_wdata_i,
  output logic                     host_ready_o,
  output vsldu_cfg_pkg::vreg_data_t host_rdata_o,
  output logic                     host_rvalid_o
);

  import vsldu_cfg_pkg::*;

  localparam int unsigned NR_WORDS = NR_VREGS * NR_WORDS_PER_VEC;

  vreg_data_t mem_q [NR_WORDS];

  logic host_rd, host_wr;

  //////////////////////////////////////////////////
  // Unit port
  //////////////////////////////////////////////////

  assign port.rdata  = mem_q[port.raddr];
  assign port.rvalid = port.re;
  // Unit writes always win
  assign port.wvalid = port.we;

  //////////////////////////////////////////////////
  // Host port
  //////////////////////////////////////////////////

  assign host_ready_o = ~port.re & ~port.we;
  assign host_rd      = host_req_i & host_ready_o & ~host_we_i;
  assign host_wr      = host_req_i & host_ready_o & host_we_i;

  always_ff @(posedge clk_i) begin
    if (port.we) begin
      for (int b = 0; b < VRF_WORD_BYTES; b++) begin
        if (port.wreq.wbe[b]) begin
          mem_q[port.wreq.waddr][b*8 +: 8] <= port.wreq.wdata[b*8 +: 8];
        end
      end
    end else if (host_wr) begin
      mem_q[host_addr_i] <= host_wdata_i;
    end
    if (host_rd) begin
      host_rdata_o <= mem_q[host_addr_i];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      host_rvalid_o <= 1'b0;
    end else begin
      host_rvalid_o <= host_rd;
    end
  end

endmodule

// ==== hw/vsldu_top.sv ====
// A new request is taken only with the unit idle and the response buffer not full
`timescale 1ns/10ps

module vsldu_top (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         req_valid_i,
  output logic                         req_ready_o,
  input  vsldu_isa_pkg::sld_op_e       req_op_i,
  input  vsldu_isa_pkg::vsew_e         req_vsew_i,
  input  vsldu_cfg_pkg::vlen_t         req_vl_i,
  input  vsldu_cfg_pkg::vlen_t         req_vstart_i,
  input  vsldu_cfg_pkg::vreg_idx_t     req_vd_i,
  input  vsldu_cfg_pkg::vreg_idx_t     req_vs2_i,
  input  logic [vsldu_cfg_pkg::ELEN-1:0] req_rs1_i,
  input  vsldu_cfg_pkg::op_id_t        req_id_i,
  output logic                         rsp_valid_o,
  input  logic                         rsp_ready_i,
  output vsldu_cfg_pkg::op_id_t        rsp_id_o,
  input  logic                         host_req_i,
  input  logic                         host_we_i,
  input  vsldu_cfg_pkg::vreg_addr_t    host_addr_i,
  input  vsldu_cfg_pkg::vreg_data_t    host_wdata_i,
  output logic                         host_ready_o,
  output vsldu_cfg_pkg::vreg_data_t    host_rdata_o,
  output logic                         host_rvalid_o
);

  import vsldu_isa_pkg::*;

  sld_req_t req;
  sld_rsp_t unit_rsp, rsp_q;
  logic     unit_rsp_valid, unit_rsp_ready;

  vrf_port_if vrf_port ();

  assign req = '{op: req_op_i, vsew: req_vsew_i, vl: req_vl_i, vstart: req_vstart_i,
                 vd: req_vd_i, vs2: req_vs2_i, rs1: req_rs1_i, id: req_id_i};

  vsldu i_vsldu (
    .clk_i      (clk_i         ),
    .rst_n_i    (rst_n_i       ),
    .req_i      (req           ),
    .req_valid_i(req_valid_i   ),
    .req_ready_o(req_ready_o   ),
    .rsp_o      (unit_rsp      ),
    .rsp_valid_o(unit_rsp_valid),
    .rsp_ready_i(unit_rsp_ready),
    .vrf        (vrf_port.unit )
  );

  vrf i_vrf (
    .clk_i        (clk_i        ),
    .rst_n_i      (rst_n_i      ),
    .port         (vrf_port.vrf ),
    .host_req_i   (host_req_i   ),
    .host_we_i    (host_we_i    ),
    .host_addr_i  (host_addr_i  ),
    .host_wdata_i (host_wdata_i ),
    .host_ready_o (host_ready_o ),
    .host_rdata_o (host_rdata_o ),
    .host_rvalid_o(host_rvalid_o)
  );

  // Completion buffer toward the requester
  spill_register #(
    .T(sld_rsp_t)
  ) i_rsp_spill (
    .clk_i  (clk_i         ),
    .rst_n_i(rst_n_i       ),
    .valid_i(unit_rsp_valid),
    .ready_o(unit_rsp_ready),
    .data_i (unit_rsp      ),
    .valid_o(rsp_valid_o   ),
    .ready_i(rsp_ready_i   ),
    .data_o (rsp_q         )
  );

  assign rsp_id_o = rsp_q.id;

endmodule

// ==== testbench/vsldu_assert.sv ====
// Bound into vsldu; refers upward to tb_vsldu_top, so the testbench top must keep that name
`timescale 1ns/10ps

module vsldu_assert (
  input logic clk_i,
  input logic rst_n_i,
  input logic busy_i,
  input logic req_valid_i,
  input logic req_ready_i,
  input logic rsp_valid_i,
  input logic rsp_ready_i,
  input logic we_i,
  input logic re_i
);

  // Set from request acceptance until the completion handshake
  logic inflight_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      inflight_q <= 1'b0;
    end else if (req_valid_i && req_ready_i) begin
      inflight_q <= 1'b1;
    end else if (rsp_valid_i && rsp_ready_i) begin
      inflight_q <= 1'b0;
    end
  end

  // Completion only once reads stopped and the last write is taken
  rsp_after_write: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i |-> !busy_i ##1 !we_i
  ) else begin
    $error("completion raised with register writes still pending");
    tb_vsldu_top.assert_fails++;
  end

  busy_blocks_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) inflight_q |-> !req_ready_i
  ) else begin
    $error("req_ready_o high while an instruction is in the unit");
    tb_vsldu_top.assert_fails++;
  end

  // Port stays idle in reset
  idle_in_reset: assert property (
    @(posedge clk_i) !rst_n_i |-> !we_i && !re_i
  ) else begin
    $error("register file port active during reset");
    tb_vsldu_top.assert_fails++;
  end

endmodule

// ==== testbench/tb_vsldu_top.sv ====
// Registers are preloaded over the host port with the unit idle; vd and vs2 always differ
`timescale 1ns/10ps

module tb_vsldu_top;

  import vsldu_cfg_pkg::*;
  import vsldu_isa_pkg::*;

  typedef logic [VLEN-1:0] vec_t;

  localparam int  NR_TESTS   = 35;
  localparam time CLK_PERIOD = 20ns;
  localparam time T_DRIVE    = 2ns;
  localparam time TIMEOUT    = NR_TESTS * 200 * CLK_PERIOD;

  logic            clk;
  logic            rst_n;
  logic            req_valid;
  logic            req_ready;
  sld_op_e         req_op;
  vsew_e           req_vsew;
  vlen_t           req_vl;
  vlen_t           req_vstart;
  vreg_idx_t       req_vd;
  vreg_idx_t       req_vs2;
  logic [ELEN-1:0] req_rs1;
  op_id_t          req_id;
  logic            rsp_valid;
  logic            rsp_ready;
  op_id_t          rsp_id;
  logic            host_req;
  logic            host_we;
  vreg_addr_t      host_addr;
  vreg_data_t      host_wdata;
  logic            host_ready;
  vreg_data_t      host_rdata;
  logic            host_rvalid;

  int        seed         = 32'h19e0;
  int        n_tests      = 0;
  int        n_failed     = 0;
  int        n_errors     = 0;
  int        assert_fails = 0;
  int        n_issued     = 0;
  int        n_checked    = 0;
  vec_t      vrf_model [NR_VREGS];
  op_id_t    rsp_seen_q [$];
  op_id_t    exp_id_q [$];
  vreg_idx_t exp_vd_q [$];
  vec_t      exp_val_q [$];
  string     name_q [$];

  vsldu_top dut0 (
    .clk_i        (clk        ),
    .rst_n_i      (rst_n      ),
    .req_valid_i  (req_valid  ),
    .req_ready_o  (req_ready  ),
    .req_op_i     (req_op     ),
    .req_vsew_i   (req_vsew   ),
    .req_vl_i     (req_vl     ),
    .req_vstart_i (req_vstart ),
    .req_vd_i     (req_vd     ),
    .req_vs2_i    (req_vs2    ),
    .req_rs1_i    (req_rs1    ),
    .req_id_i     (req_id     ),
    .rsp_valid_o  (rsp_valid  ),
    .rsp_ready_i  (rsp_ready  ),
    .rsp_id_o     (rsp_id     ),
    .host_req_i   (host_req   ),
    .host_we_i    (host_we    ),
    .host_addr_i  (host_addr  ),
    .host_wdata_i (host_wdata ),
    .host_ready_o (host_ready ),
    .host_rdata_o (host_rdata ),
    .host_rvalid_o(host_rvalid)
  );

  bind vsldu vsldu_assert i_assert (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .busy_i     (busy_q     ),
    .req_valid_i(req_valid_i),
    .req_ready_i(req_ready_o),
    .rsp_valid_i(rsp_valid_o),
    .rsp_ready_i(rsp_ready_i),
    .we_i       (vrf.we     ),
    .re_i       (vrf.re     )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic int unsigned rand_below(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Element-wise result; elements outside the written range keep old_vd
  function automatic vec_t expect_vd(sld_op_e op, vsew_e vsew, int vl, int vstart,
                                     logic [31:0] rs1, vec_t old_vd, vec_t src);
    vec_t        res;
    int          eb;
    int          vlmax;
    int          amt;
    int          j;
    logic        take;
    logic        use_rs1;
    logic [31:0] elem;
    res   = old_vd;
    eb    = 1 << vsew;
    vlmax = MAXVL_BYTES / eb;
    amt   = (rs1 >= vlmax) ? vlmax : int'(rs1);
    if (op == OP_SLIDE1UP || op == OP_SLIDE1DOWN) begin
      amt = 1;
    end
    for (int i = vstart; i < vl; i++) begin
      take    = 1'b1;
      use_rs1 = 1'b0;
      j       = 0;
      case (op)
        OP_SLIDEUP: begin
          take = (i >= amt);
          j    = i - amt;
        end
        OP_SLIDEDOWN: j = i + amt;
        OP_SLIDE1UP: begin
          use_rs1 = (i == 0);
          j       = i - 1;
        end
        OP_SLIDE1DOWN: begin
          use_rs1 = (i == vl - 1);
          j       = i + 1;
        end
        default: begin
          take    = (i == 0);
          use_rs1 = 1'b1;
        end
      endcase
      elem = '0;
      if (use_rs1) begin
        elem = rs1;
      end else if (j >= 0 && j < vlmax) begin
        for (int b = 0; b < eb; b++) begin
          elem[b*8 +: 8] = src[(j*eb+b)*8 +: 8];
        end
      end
      if (take) begin
        for (int b = 0; b < eb; b++) begin
          res[(i*eb+b)*8 +: 8] = elem[b*8 +: 8];
        end
      end
    end
    return res;
  endfunction

  //////////////////////////////////////////////////
  // Bus tasks
  //////////////////////////////////////////////////

  task automatic report_test(string name, int errs);
    n_tests++;
    n_errors += errs;
    if (errs != 0) begin
      n_failed++;
    end
    $display("%0t test %0d %s: %s", $time, n_tests, name, (errs == 0) ? "passed" : "failed");
  endtask

  task automatic host_access(logic we, vreg_addr_t addr, vreg_data_t wdata);
    @(posedge clk);
    #T_DRIVE;
    host_req   = 1'b1;
    host_we    = we;
    host_addr  = addr;
    host_wdata = wdata;
    do begin
      @(negedge clk);
    end while (!host_ready);
    @(posedge clk);
    #T_DRIVE;
    host_req = 1'b0;
  endtask

  task automatic host_read(vreg_addr_t addr, output vreg_data_t data);
    host_access(1'b0, addr, '0);
    @(negedge clk);
    if (!host_rvalid) begin
      $display("ERROR %0t: host read of word %0d returned no data", $time, addr);
      n_errors++;
    end
    data = host_rdata;
  endtask

  // Queues the expected result, then raises req_valid
  task automatic drive_req(string name, sld_op_e op, vsew_e vsew, int vl, int vstart,
                           vreg_idx_t vd, vreg_idx_t vs2, logic [31:0] rs1);
    vec_t want;
    want = expect_vd(op, vsew, vl, vstart, rs1, vrf_model[vd], vrf_model[vs2]);
    vrf_model[vd] = want;
    exp_id_q.push_back(op_id_t'(n_issued));
    exp_vd_q.push_back(vd);
    exp_val_q.push_back(want);
    name_q.push_back(name);
    @(posedge clk);
    #T_DRIVE;
    req_valid  = 1'b1;
    req_op     = op;
    req_vsew   = vsew;
    req_vl     = vlen_t'(vl);
    req_vstart = vlen_t'(vstart);
    req_vd     = vd;
    req_vs2    = vs2;
    req_rs1    = rs1;
    req_id     = op_id_t'(n_issued);
    n_issued++;
  endtask

  task automatic wait_accept();
    do begin
      @(negedge clk);
    end while (!req_ready);
    @(posedge clk);
    #T_DRIVE;
    req_valid = 1'b0;
  endtask

  task automatic run_random(string name, sld_op_e op, vsew_e vsew, int vl, int vstart,
                            logic [31:0] rs1);
    vreg_idx_t vd;
    vreg_idx_t vs2;
    vd  = vreg_idx_t'(rand_below(NR_VREGS));
    vs2 = vd + vreg_idx_t'(1 + rand_below(NR_VREGS - 1));
    drive_req($sformatf("%s sew %0d", name, 8 << vsew), op, vsew, vl, vstart, vd, vs2, rs1);
    wait_accept();
    wait (n_checked == n_issued);
  endtask

  //////////////////////////////////////////////////
  // Response capture and compare
  //////////////////////////////////////////////////

  initial begin : rsp_capture
    forever begin
      @(negedge clk);
      if (rst_n && rsp_valid && rsp_ready) begin
        rsp_seen_q.push_back(rsp_id);
      end
    end
  end

  initial begin : compare_proc
    op_id_t     got_id;
    op_id_t     want_id;
    vreg_idx_t  vd;
    vec_t       want;
    string      name;
    vreg_data_t word;
    int         errs;
    forever begin
      wait (rsp_seen_q.size() > 0);
      got_id = rsp_seen_q.pop_front();
      if (exp_id_q.size() == 0) begin
        $display("ERROR %0t: response id %0d arrived with no request pending", $time, got_id);
        n_errors++;
      end else begin
        want_id = exp_id_q.pop_front();
        vd      = exp_vd_q.pop_front();
        want    = exp_val_q.pop_front();
        name    = name_q.pop_front();
        errs    = 0;
        if (got_id !== want_id) begin
          $display("FAIL %0t rsp_id_o got %0d expected %0d", $time, got_id, want_id);
          errs++;
        end
        for (int w = 0; w < NR_WORDS_PER_VEC; w++) begin
          host_read(vreg_addr_t'(vd * NR_WORDS_PER_VEC + w), word);
          if (word !== want[w*64 +: 64]) begin
            $display("FAIL %0t host_rdata_o (v%0d word %0d) got %h expected %h",
                     $time, vd, w, word, want[w*64 +: 64]);
            errs++;
          end
        end
        report_test(name, errs);
        n_checked++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin : main_proc
    int         vlmax;
    int         vl;
    int         vst;
    int         errs;
    op_id_t     held_id;
    vreg_data_t data;
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req_op     = OP_SLIDEUP;
    req_vsew   = EW_8;
    req_vl     = '0;
    req_vstart = '0;
    req_vd     = '0;
    req_vs2    = '0;
    req_rs1    = '0;
    req_id     = '0;
    rsp_ready  = 1'b1;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    repeat (8) @(posedge clk);
    #T_DRIVE;
    rst_n = 1'b1;

    @(negedge clk);
    errs = 0;
    if (req_ready !== 1'b1) begin
      $display("FAIL %0t req_ready_o got %b expected 1", $time, req_ready);
      errs++;
    end
    if (rsp_valid !== 1'b0) begin
      $display("FAIL %0t rsp_valid_o got %b expected 0", $time, rsp_valid);
      errs++;
    end
    if (host_rvalid !== 1'b0) begin
      $display("FAIL %0t host_rvalid_o got %b expected 0", $time, host_rvalid);
      errs++;
    end
    report_test("reset state", errs);

    for (int r = 0; r < NR_VREGS; r++) begin
      for (int w = 0; w < NR_WORDS_PER_VEC; w++) begin
        data = {$random(seed), $random(seed)};
        host_access(1'b1, vreg_addr_t'(r * NR_WORDS_PER_VEC + w), data);
        vrf_model[r][w*64 +: 64] = data;
      end
    end

    // Full-length slides by a random amount
    for (int s = 0; s < 3; s++) begin
      vlmax = MAXVL_BYTES >> s;
      for (int k = 0; k < 2; k++) begin
        run_random("slide up full", OP_SLIDEUP, vsew_e'(s), vlmax, 0, rand_below(vlmax));
        run_random("slide down full", OP_SLIDEDOWN, vsew_e'(s), vlmax, 0, rand_below(vlmax));
      end
    end

    // Nonzero vstart with a short vl
    for (int s = 0; s < 3; s++) begin
      vlmax = MAXVL_BYTES >> s;
      vst   = 1 + rand_below(vlmax / 2);
      vl    = vst + 1 + rand_below(vlmax - vst - 1);
      run_random("slide up partial", OP_SLIDEUP, vsew_e'(s), vl, vst, rand_below(vlmax));
      run_random("slide down partial", OP_SLIDEDOWN, vsew_e'(s), vl, vst, rand_below(vlmax));
    end

    for (int s = 0; s < 3; s++) begin
      vlmax = MAXVL_BYTES >> s;
      run_random("slide1up", OP_SLIDE1UP, vsew_e'(s), vlmax, 0, $random(seed));
      run_random("slide1down", OP_SLIDE1DOWN, vsew_e'(s), 1 + rand_below(vlmax), 0,
                 $random(seed));
    end

    for (int s = 0; s < 3; s++) begin
      run_random("scalar move", OP_VMVSX, vsew_e'(s), 1, 0, $random(seed));
    end

    // Amount past the end of vs2 gives zeros
    for (int s = 0; s < 3; s++) begin
      vlmax = MAXVL_BYTES >> s;
      run_random("slide down past end", OP_SLIDEDOWN, vsew_e'(s), vlmax,
                 rand_below(vlmax / 2), vlmax + rand_below(64));
    end

    // Back-pressure, two responses fill the buffer and a third request must wait
    @(posedge clk);
    #T_DRIVE;
    rsp_ready = 1'b0;
    errs      = 0;
    drive_req("held A", OP_SLIDEUP, EW_32, 8, 0, 5'd1, 5'd10, 32'd2);
    wait_accept();
    // Unit reads vs2 in the cycle after acceptance, so the host port is blocked
    @(negedge clk);
    if (host_ready !== 1'b0) begin
      $display("FAIL %0t host_ready_o got %b expected 0", $time, host_ready);
      errs++;
    end
    drive_req("held B", OP_SLIDEDOWN, EW_16, 16, 0, 5'd2, 5'd11, 32'd3);
    wait_accept();
    drive_req("held C", OP_SLIDE1UP, EW_8, 32, 0, 5'd3, 5'd12, $random(seed));
    held_id = op_id_t'(n_issued - 3);
    repeat (40) begin
      @(negedge clk);
      if (req_ready !== 1'b0) begin
        $display("FAIL %0t req_ready_o got %b expected 0", $time, req_ready);
        errs++;
      end
      if (rsp_valid !== 1'b1) begin
        $display("FAIL %0t rsp_valid_o got %b expected 1", $time, rsp_valid);
        errs++;
      end
      if (rsp_id !== held_id) begin
        $display("FAIL %0t rsp_id_o got %0d expected %0d", $time, rsp_id, held_id);
        errs++;
      end
    end
    report_test("back-pressure hold", errs);
    @(posedge clk);
    #T_DRIVE;
    rsp_ready = 1'b1;
    wait_accept();
    wait (n_checked == n_issued);

    $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
             n_tests, n_failed, n_errors, assert_fails);
    if (n_errors == 0 && assert_fails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT);
    $display("ERROR: run did not finish within %0t", TIMEOUT);
    $display("Something failed");
    $finish;
  end

endmodule

// ==== vsldu_top.f ====
hw/vsldu_cfg_pkg.sv
hw/vsldu_isa_pkg.sv
hw/vrf_port_if.sv
hw/spill_register.sv
hw/vsldu.sv
hw/vrf.sv
hw/vsldu_top.sv
testbench/vsldu_assert.sv
testbench/tb_vsldu_top.sv

// ==== Bender.yml ====
package:
  name: vsldu

sources:
  # RTL in compile order
  - files:
      - hw/vsldu_cfg_pkg.sv
      - hw/vsldu_isa_pkg.sv
      - hw/vrf_port_if.sv
      - hw/spill_register.sv
      - hw/vsldu.sv
      - hw/vrf.sv
      - hw/vsldu_top.sv

  # Testbench
  - target: test
    files:
      - testbench/vsldu_assert.sv
      - testbench/tb_vsldu_top.sv
